/* flist.f */
+incdir+verilog
verilog/axis_pkg.sv
verilog/frame_pkg.sv
verilog/axis_frame_fifo.sv
verilog/axis_frame_arbiter.sv
verilog/frame_stats.sv
verilog/axis_ingress_top.sv
tb/tb_ingress.sv

/* Makefile */
SRCS = verilog/stream_macros.svh \
       verilog/axis_pkg.sv \
       verilog/frame_pkg.sv \
       verilog/axis_frame_fifo.sv \
       verilog/axis_frame_arbiter.sv \
       verilog/frame_stats.sv \
       verilog/axis_ingress_top.sv \
       tb/tb_ingress.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_ingress: $(SRCS) flist.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ingress \
	  -f flist.f -o Vtb_ingress

run: obj_dir/Vtb_ingress
	-./obj_dir/Vtb_ingress > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_ingress.sv */
`timescale 1ns/1ps
`include "stream_macros.svh"

module tb_ingress;

  localparam int MAX_FRAME = 1 << `FIFO_ADDR_WIDTH;  // frame FIFO depth in beats
  localparam int RANDOM_ROUNDS = 12;

  logic                    clk;
  logic                    rst;
  axis_pkg::tdata_t        s0_tdata, s1_tdata;
  axis_pkg::tkeep_t        s0_tkeep, s1_tkeep;
  axis_pkg::tuser_t        s0_tuser, s1_tuser;
  logic                    s0_tlast, s1_tlast;
  logic                    s0_tvalid, s1_tvalid;
  logic                    s0_tready, s1_tready;
  axis_pkg::tdata_t        m_tdata;
  axis_pkg::tkeep_t        m_tkeep;
  frame_pkg::port_id_t     m_tid;
  logic                    m_tlast;
  logic                    m_tvalid;
  logic                    m_tready;
  frame_pkg::frame_count_t good_count_0, bad_count_0, overflow_count_0;
  frame_pkg::frame_count_t good_count_1, bad_count_1, overflow_count_1;

  // expected output beats per source port, in order of arrival
  axis_pkg::tdata_t        exp_data [2][$];
  axis_pkg::tkeep_t        exp_keep [2][$];
  logic                    exp_last [2][$];
  frame_pkg::port_id_t     frame_order [$];  // source port of each output frame
  frame_pkg::frame_count_t model_good [2];
  frame_pkg::frame_count_t model_bad [2];
  frame_pkg::frame_count_t model_ovf [2];

  int  stall_cycles [2];
  int  rand_len [RANDOM_ROUNDS][2];
  bit  rand_bad [RANDOM_ROUNDS][2];
  int  total_beats = 0;
  bit  plan_done = 1'b0;
  bit  random_backpressure = 1'b0;
  logic in_frame;
  frame_pkg::port_id_t cur_port;

  axis_ingress_top axis_ingress_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // **********************************************************************
  // checks
  // **********************************************************************
  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_beat(input axis_pkg::tdata_t got_data, input axis_pkg::tdata_t want_data,
                            input axis_pkg::tkeep_t got_keep, input axis_pkg::tkeep_t want_keep,
                            input logic got_last, input logic want_last,
                            input frame_pkg::port_id_t got_id,
                            input frame_pkg::port_id_t want_id);
    if (got_data !== want_data || got_keep !== want_keep || got_last !== want_last ||
        got_id !== want_id) begin
      report_error($sformatf("output beat got data %h keep %h last %b tid %0d, %s %h %h %b %0d",
                             got_data, got_keep, got_last, got_id, "expected",
                             want_data, want_keep, want_last, want_id));
    end
  endtask

  task automatic check_count(input string name, input frame_pkg::frame_count_t got,
                             input frame_pkg::frame_count_t want);
    if (got !== want) begin
      report_error($sformatf("%s is %0d, expected %0d", name, got, want));
    end
  endtask

  task automatic check_counters();
    check_count("good_count_0", good_count_0, model_good[0]);
    check_count("bad_count_0", bad_count_0, model_bad[0]);
    check_count("overflow_count_0", overflow_count_0, model_ovf[0]);
    check_count("good_count_1", good_count_1, model_good[1]);
    check_count("bad_count_1", bad_count_1, model_bad[1]);
    check_count("overflow_count_1", overflow_count_1, model_ovf[1]);
  endtask

  // the source port of a new frame is found from the head beats of the model queues
  task automatic take_output_beat();
    int p;
    if (in_frame && m_tid != cur_port) begin
      report_error($sformatf("a beat from port %0d cut into a frame from port %0d",
                             m_tid, cur_port));
    end
    if (in_frame) begin
      p = int'(cur_port);
    end else if (exp_data[0].size() != 0 && exp_data[0][0] === m_tdata) begin
      p = 0;
    end else if (exp_data[1].size() != 0 && exp_data[1][0] === m_tdata) begin
      p = 1;
    end else begin
      p = 0;
      report_error($sformatf("a frame starting with data %h matches no expected frame",
                             m_tdata));
    end
    if (exp_data[p].size() == 0) begin
      report_error($sformatf("port %0d sent a beat that no good frame accounts for", p));
    end
    if (!in_frame) begin
      frame_order.push_back(frame_pkg::port_id_t'(p));
    end
    check_beat(m_tdata, exp_data[p].pop_front(), m_tkeep, exp_keep[p].pop_front(),
               m_tlast, exp_last[p].pop_front(), m_tid, frame_pkg::port_id_t'(p));
    in_frame = !m_tlast;
    cur_port = frame_pkg::port_id_t'(p);
  endtask

  initial begin : output_monitor
    in_frame = 1'b0;
    cur_port = '0;
    forever begin
      @(posedge clk);
      if (!rst && m_tvalid && m_tready) begin
        take_output_beat();
      end
    end
  end

  initial begin : ready_driver
    m_tready <= 1'b1;
    forever begin
      @(posedge clk);
      if (random_backpressure) begin
        m_tready <= ($urandom_range(3, 0) != 0);  // low on about a quarter of the cycles
      end else begin
        m_tready <= 1'b1;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (plan_done);
    limit = total_beats * 20 + 1000;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d clock cycles", limit);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  // **********************************************************************
  // stimulus
  // **********************************************************************
  function automatic logic port_ready(input int port);
    return (port == 0) ? s0_tready : s1_tready;
  endfunction

  task automatic drive_port(input int port, input logic valid, input axis_pkg::tdata_t data,
                            input axis_pkg::tkeep_t keep, input axis_pkg::tuser_t user,
                            input logic last);
    if (port == 0) begin
      s0_tvalid <= valid;
      s0_tdata <= data;
      s0_tkeep <= keep;
      s0_tuser <= user;
      s0_tlast <= last;
    end else begin
      s1_tvalid <= valid;
      s1_tdata <= data;
      s1_tkeep <= keep;
      s1_tuser <= user;
      s1_tlast <= last;
    end
  endtask

  // a long frame is only sent into an empty FIFO, so its length alone decides overflow
  task automatic send_frame(input int port, input int len, input bit bad, input int frame_id,
                            input bit rand_fill, input int max_gap);
    axis_pkg::tdata_t data;
    axis_pkg::tkeep_t keep;
    axis_pkg::tuser_t user;
    logic             last;
    int               gap;
    @(posedge clk);
    for (int i = 0; i < len; i++) begin
      last = (i == len - 1);
      if (rand_fill) begin
        data = axis_pkg::tdata_t'($urandom);
        keep = last ? axis_pkg::tkeep_t'($urandom_range(15, 1)) : '1;
      end else begin
        data = {8'(frame_id), 8'(port), 16'(i)};
        keep = last ? axis_pkg::tkeep_t'(3) : '1;
      end
      user = '0;
      user[`BAD_FRAME_BIT] = last && bad;
      if (!bad && len <= MAX_FRAME) begin
        exp_data[port].push_back(data);
        exp_keep[port].push_back(keep);
        exp_last[port].push_back(last);
      end
      drive_port(port, 1'b1, data, keep, user, last);
      @(posedge clk);
      while (!port_ready(port)) begin
        stall_cycles[port]++;
        @(posedge clk);
      end
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      if (gap > 0) begin
        drive_port(port, 1'b0, data, keep, user, last);
        repeat (gap) @(posedge clk);
      end
    end
    drive_port(port, 1'b0, '0, '0, '0, 1'b0);
    if (len > MAX_FRAME) begin
      model_ovf[port] = model_ovf[port] + frame_pkg::frame_count_t'(1);
    end else if (bad) begin
      model_bad[port] = model_bad[port] + frame_pkg::frame_count_t'(1);
    end else begin
      model_good[port] = model_good[port] + frame_pkg::frame_count_t'(1);
    end
  endtask

  task automatic wait_drain();
    while (exp_data[0].size() != 0 || exp_data[1].size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // counters trail the last input beat by 2 cycles
  endtask

  // **********************************************************************
  // tests
  // **********************************************************************
  task automatic test_single_good_frame();
    send_frame(0, 5, 1'b0, 1, 1'b0, 0);
    wait_drain();
    check_counters();
  endtask

  task automatic test_bad_frame_drop();
    send_frame(1, 4, 1'b1, 2, 1'b0, 0);
    send_frame(1, 3, 1'b0, 3, 1'b0, 0);
    wait_drain();
    check_counters();
  endtask

  task automatic test_overflow_drop();
    stall_cycles[0] = 0;
    send_frame(0, MAX_FRAME + 4, 1'b0, 4, 1'b0, 0);
    if (stall_cycles[0] != 0) begin
      report_error($sformatf("s0_tready was low for %0d cycles of the long frame",
                             stall_cycles[0]));
    end
    send_frame(0, 4, 1'b0, 5, 1'b0, 0);
    wait_drain();
    check_counters();
  endtask

  task automatic test_round_robin_merge();
    int first;
    first = frame_order.size();
    fork
      begin
        for (int f = 0; f < 3; f++) send_frame(0, 4, 1'b0, 16 + f, 1'b0, 0);
      end
      begin
        for (int f = 0; f < 3; f++) send_frame(1, 4, 1'b0, 32 + f, 1'b0, 0);
      end
    join
    wait_drain();
    if (frame_order.size() - first != 6) begin
      report_error($sformatf("%0d frames came out, expected 6", frame_order.size() - first));
    end
    for (int i = first + 1; i < frame_order.size(); i++) begin
      if (frame_order[i] == frame_order[i - 1]) begin
        report_error($sformatf("port %0d was served twice in a row", frame_order[i]));
      end
    end
    check_counters();
  endtask

  task automatic test_random_backpressure();
    random_backpressure = 1'b1;
    for (int r = 0; r < RANDOM_ROUNDS; r++) begin
      fork
        send_frame(0, rand_len[r][0], rand_bad[r][0], 64 + r, 1'b1, 2);
        send_frame(1, rand_len[r][1], rand_bad[r][1], 96 + r, 1'b1, 2);
      join
      wait_drain();
    end
    random_backpressure = 1'b0;
    wait_drain();
    check_counters();
  endtask

  initial begin : main
    void'($urandom(76));
    rst <= 1'b1;
    drive_port(0, 1'b0, '0, '0, '0, 1'b0);
    drive_port(1, 1'b0, '0, '0, '0, 1'b0);
    for (int p = 0; p < 2; p++) begin
      model_good[p] = '0;
      model_bad[p] = '0;
      model_ovf[p] = '0;
    end
    total_beats = 5 + 4 + 3 + (MAX_FRAME + 4) + 4 + 6 * 4;  // directed tests
    for (int r = 0; r < RANDOM_ROUNDS; r++) begin
      for (int p = 0; p < 2; p++) begin
        rand_len[r][p] = $urandom_range(MAX_FRAME, 1);
        rand_bad[r][p] = ($urandom_range(4, 0) == 0);
        total_beats += rand_len[r][p];
      end
    end
    plan_done = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_single_good_frame();
    test_bad_frame_drop();
    test_overflow_drop();
    test_round_robin_merge();
    test_random_backpressure();
    repeat (50) @(posedge clk);  // a stray beat would still reach the monitor here
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verilog/axis_ingress_top.sv */
`timescale 1ns/1ps

module axis_ingress_top (
  input  logic                    clk,
  input  logic                    rst,
  input  axis_pkg::tdata_t        s0_tdata,
  input  axis_pkg::tkeep_t        s0_tkeep,
  input  axis_pkg::tuser_t        s0_tuser,
  input  logic                    s0_tlast,
  input  logic                    s0_tvalid,
  output logic                    s0_tready,
  input  axis_pkg::tdata_t        s1_tdata,
  input  axis_pkg::tkeep_t        s1_tkeep,
  input  axis_pkg::tuser_t        s1_tuser,
  input  logic                    s1_tlast,
  input  logic                    s1_tvalid,
  output logic                    s1_tready,
  output axis_pkg::tdata_t        m_tdata,
  output axis_pkg::tkeep_t        m_tkeep,
  output frame_pkg::port_id_t     m_tid,
  output logic                    m_tlast,
  output logic                    m_tvalid,
  input  logic                    m_tready,
  output frame_pkg::frame_count_t good_count_0,
  output frame_pkg::frame_count_t bad_count_0,
  output frame_pkg::frame_count_t overflow_count_0,
  output frame_pkg::frame_count_t good_count_1,
  output frame_pkg::frame_count_t bad_count_1,
  output frame_pkg::frame_count_t overflow_count_1
);

  axis_pkg::tdata_t f0_tdata, f1_tdata;
  axis_pkg::tkeep_t f0_tkeep, f1_tkeep;
  logic             f0_tlast, f1_tlast;
  logic             f0_tvalid, f1_tvalid;
  logic             f0_tready, f1_tready;
  logic             good_0, bad_0, ovf_0;
  logic             good_1, bad_1, ovf_1;

  // **********************************************************************
  // per-port buffering and accounting
  // **********************************************************************
  axis_frame_fifo fifo_0 (
    .clk(clk), .rst(rst),
    .s_tdata(s0_tdata), .s_tkeep(s0_tkeep), .s_tuser(s0_tuser),
    .s_tlast(s0_tlast), .s_tvalid(s0_tvalid), .s_tready(s0_tready),
    .m_tdata(f0_tdata), .m_tkeep(f0_tkeep), .m_tlast(f0_tlast),
    .m_tvalid(f0_tvalid), .m_tready(f0_tready),
    .status_good_frame(good_0), .status_bad_frame(bad_0), .status_overflow(ovf_0)
  );

  axis_frame_fifo fifo_1 (
    .clk(clk), .rst(rst),
    .s_tdata(s1_tdata), .s_tkeep(s1_tkeep), .s_tuser(s1_tuser),
    .s_tlast(s1_tlast), .s_tvalid(s1_tvalid), .s_tready(s1_tready),
    .m_tdata(f1_tdata), .m_tkeep(f1_tkeep), .m_tlast(f1_tlast),
    .m_tvalid(f1_tvalid), .m_tready(f1_tready),
    .status_good_frame(good_1), .status_bad_frame(bad_1), .status_overflow(ovf_1)
  );

  frame_stats stats_0 (
    .clk(clk), .rst(rst),
    .good_frame(good_0), .bad_frame(bad_0), .overflow(ovf_0),
    .good_count(good_count_0), .bad_count(bad_count_0), .overflow_count(overflow_count_0)
  );

  frame_stats stats_1 (
    .clk(clk), .rst(rst),
    .good_frame(good_1), .bad_frame(bad_1), .overflow(ovf_1),
    .good_count(good_count_1), .bad_count(bad_count_1), .overflow_count(overflow_count_1)
  );

  // merge of both ports onto the egress stream
  axis_frame_arbiter arb (
    .clk(clk), .rst(rst),
    .s0_tdata(f0_tdata), .s1_tdata(f1_tdata),
    .s0_tkeep(f0_tkeep), .s1_tkeep(f1_tkeep),
    .s0_tlast(f0_tlast), .s1_tlast(f1_tlast),
    .s0_tvalid(f0_tvalid), .s1_tvalid(f1_tvalid),
    .s0_tready(f0_tready), .s1_tready(f1_tready),
    .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tid(m_tid),
    .m_tlast(m_tlast), .m_tvalid(m_tvalid), .m_tready(m_tready)
  );

endmodule

/* verilog/frame_stats.sv */
`timescale 1ns/1ps

module frame_stats (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    good_frame,
  input  logic                    bad_frame,
  input  logic                    overflow,
  output frame_pkg::frame_count_t good_count,
  output frame_pkg::frame_count_t bad_count,
  output frame_pkg::frame_count_t overflow_count
);

  // holds at all ones instead of wrapping
  function automatic frame_pkg::frame_count_t sat_inc(input frame_pkg::frame_count_t cnt);
    frame_pkg::frame_count_t nxt;
    nxt = cnt + 1'b1;
    return (&cnt) ? cnt : nxt;
  endfunction

  // **********************************************************************
  // per-port frame counters
  // **********************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      good_count <= '0;
      bad_count <= '0;
      overflow_count <= '0;
    end else begin
      if (good_frame) begin
        good_count <= sat_inc(good_count);
      end
      if (bad_frame) begin
        bad_count <= sat_inc(bad_count);
      end
      if (overflow) begin
        overflow_count <= sat_inc(overflow_count);
      end
    end
  end

endmodule

/* verilog/axis_frame_arbiter.sv */
`timescale 1ns/1ps

module axis_frame_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  axis_pkg::tdata_t    s0_tdata,
  input  axis_pkg::tdata_t    s1_tdata,
  input  axis_pkg::tkeep_t    s0_tkeep,
  input  axis_pkg::tkeep_t    s1_tkeep,
  input  logic                s0_tlast,
  input  logic                s1_tlast,
  input  logic                s0_tvalid,
  input  logic                s1_tvalid,
  output logic                s0_tready,
  output logic                s1_tready,
  output axis_pkg::tdata_t    m_tdata,
  output axis_pkg::tkeep_t    m_tkeep,
  output frame_pkg::port_id_t m_tid,
  output logic                m_tlast,
  output logic                m_tvalid,
  input  logic                m_tready
);

  frame_pkg::port_id_t grant;  // port of the current or most recent frame
  frame_pkg::port_id_t sel;
  logic                busy;   // inside a frame, grant is locked

  logic             other_valid;
  logic             sel_valid;
  logic             sel_last;
  axis_pkg::tdata_t sel_tdata;
  axis_pkg::tkeep_t sel_tkeep;
  logic             out_ready;
  logic             accept;

  // **********************************************************************
  // port selection
  // **********************************************************************
  assign other_valid = grant ? s0_tvalid : s1_tvalid;

  always_comb begin
    sel = grant;
    if (!busy && other_valid) begin
      sel = ~grant;  // at a boundary the port not served last goes first
    end
  end

  assign sel_valid = sel ? s1_tvalid : s0_tvalid;
  assign sel_last = sel ? s1_tlast : s0_tlast;
  assign sel_tdata = sel ? s1_tdata : s0_tdata;
  assign sel_tkeep = sel ? s1_tkeep : s0_tkeep;

  assign out_ready = m_tready || !m_tvalid;
  assign accept = sel_valid && out_ready;
  assign s0_tready = out_ready && !sel;
  assign s1_tready = out_ready && sel;

  // **********************************************************************
  // grant state and output register
  // **********************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      busy <= 1'b0;
      m_tvalid <= 1'b0;
    end else begin
      if (accept) begin
        grant <= sel;
        busy <= !sel_last;
      end
      if (out_ready) begin
        m_tvalid <= accept;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m_tdata <= sel_tdata;
      m_tkeep <= sel_tkeep;
      m_tlast <= sel_last;
      m_tid <= sel;  // tag with the source port
    end
  end

  // frames from the two ports never interleave
  assert property (@(posedge clk) disable iff (rst) busy |=> $stable(grant));

endmodule

/* verilog/axis_frame_fifo.sv */
`timescale 1ns/1ps
`include "stream_macros.svh"

module axis_frame_fifo (
  input  logic             clk,
  input  logic             rst,
  input  axis_pkg::tdata_t s_tdata,
  input  axis_pkg::tkeep_t s_tkeep,
  input  axis_pkg::tuser_t s_tuser,
  input  logic             s_tlast,
  input  logic             s_tvalid,
  output logic             s_tready,
  output axis_pkg::tdata_t m_tdata,
  output axis_pkg::tkeep_t m_tkeep,
  output logic             m_tlast,
  output logic             m_tvalid,
  input  logic             m_tready,
  output logic             status_good_frame,
  output logic             status_bad_frame,
  output logic             status_overflow
);

  localparam int AW = `FIFO_ADDR_WIDTH;
  localparam int DEPTH = 1 << AW;
  localparam int KEEP_LSB = $bits(axis_pkg::tdata_t);
  localparam int LAST_BIT = KEEP_LSB + $bits(axis_pkg::tkeep_t);
  localparam int WORD_WIDTH = LAST_BIT + 1;

  logic [WORD_WIDTH-1:0] mem [DEPTH];

  logic [AW:0] wr_ptr, wr_ptr_next;          // end of the last committed frame
  logic [AW:0] wr_ptr_cur, wr_ptr_cur_next;  // speculative, runs ahead inside a frame
  logic [AW:0] wr_ptr_rd;                    // committed pointer as seen by the read side
  logic [AW:0] rd_ptr;

  logic ready_reg;
  logic drop_frame, drop_frame_next;
  logic good_next, bad_next, overflow_next;
  logic write, read, store_output;
  logic full_cur, empty;

  logic [WORD_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  logic [WORD_WIDTH-1:0] out_data;
  logic                  out_valid;

  // **********************************************************************
  // write side
  // **********************************************************************
  assign s_tready = ready_reg;  // never stalls, oversized frames are dropped instead
  assign full_cur = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                    (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);

  always_comb begin
    write = 1'b0;
    wr_ptr_next = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    good_next = 1'b0;
    bad_next = 1'b0;
    overflow_next = 1'b0;
    if (s_tvalid && ready_reg) begin
      if (full_cur || drop_frame) begin
        drop_frame_next = 1'b1;  // swallow the rest of the frame
        if (s_tlast) begin
          drop_frame_next = 1'b0;
          wr_ptr_cur_next = wr_ptr;
          overflow_next = 1'b1;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_tlast) begin
          if (s_tuser[`BAD_FRAME_BIT]) begin
            wr_ptr_cur_next = wr_ptr;  // rewind over the bad frame
            bad_next = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;
            good_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_reg <= 1'b0;
      wr_ptr <= '0;
      wr_ptr_cur <= '0;
      wr_ptr_rd <= '0;
      drop_frame <= 1'b0;
      status_good_frame <= 1'b0;
      status_bad_frame <= 1'b0;
      status_overflow <= 1'b0;
    end else begin
      ready_reg <= 1'b1;
      wr_ptr <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      wr_ptr_rd <= wr_ptr;  // commit reaches the read side one cycle later
      drop_frame <= drop_frame_next;
      status_good_frame <= good_next;
      status_bad_frame <= bad_next;
      status_overflow <= overflow_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[AW-1:0]] <= {s_tlast, s_tkeep, s_tdata};
    end
  end

  // **********************************************************************
  // read side, memory read register then output register
  // **********************************************************************
  assign empty = (wr_ptr_rd == rd_ptr);
  assign store_output = m_tready || !out_valid;
  assign read = (store_output || !rd_valid) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      rd_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (store_output || !rd_valid) begin
        rd_valid <= !empty;
      end
      if (store_output) begin
        out_valid <= rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem[rd_ptr[AW-1:0]];
    end
    if (store_output) begin
      out_data <= rd_data;
    end
  end

  assign m_tdata = out_data[KEEP_LSB-1:0];
  assign m_tkeep = out_data[LAST_BIT-1:KEEP_LSB];
  assign m_tlast = out_data[LAST_BIT];
  assign m_tvalid = out_valid;

  // a stalled beat stays offered until it is taken
  assert property (@(posedge clk) disable iff (rst) m_tvalid && !m_tready |=> m_tvalid);

  assert property (@(posedge clk) disable iff (rst)
    $onehot0({status_good_frame, status_bad_frame, status_overflow}));

endmodule

/* verilog/frame_pkg.sv */
`include "stream_macros.svh"

package frame_pkg;

  // **********************************************************************
  // frame accounting and port selection
  // **********************************************************************

  // number of the ingress port a frame came from
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;

  // value of one saturating statistics counter
  typedef logic [`COUNT_WIDTH-1:0] frame_count_t;

endpackage

/* verilog/axis_pkg.sv */
`include "stream_macros.svh"

package axis_pkg;

  // **********************************************************************
  // stream beat fields
  // **********************************************************************

  // payload of one beat
  typedef logic [`STREAM_DATA_WIDTH-1:0] tdata_t;

  // byte enables, one per tdata byte
  typedef logic [`STREAM_KEEP_WIDTH-1:0] tkeep_t;

  // sideband flags, only the bad-frame bit is defined
  typedef logic [0:0] tuser_t;

endpackage

/* verilog/stream_macros.svh */
`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// **********************************************************************
// stream widths
// **********************************************************************
`define STREAM_DATA_WIDTH 32  // tdata bits per beat
`define STREAM_KEEP_WIDTH 4   // one keep bit per data byte

// **********************************************************************
// buffering and accounting
// **********************************************************************
`define FIFO_ADDR_WIDTH 4     // 16 beats per frame FIFO
`define COUNT_WIDTH 16        // statistics counter width
`define BAD_FRAME_BIT 0       // tuser bit flagging a bad frame on the last beat
`define NUM_PORTS 2           // ingress ports merged by the arbiter

`endif
